/* core.f */
verilog/core_pkg.sv
verilog/fetch_ctrl.sv
verilog/stable_timer.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/exec_stage.sv
verilog/core.sv
tests/core_asserts.sv
tests/core_tb.sv

/* tests/core_asserts.sv */
`default_nettype none

module core_asserts (
    input logic                clk,
    input logic                rst_n,
    input logic                inst_re,
    input core_pkg::word_t     inst_addr,
    input logic [3:0]          debug_wb_rf_we,
    input core_pkg::reg_addr_t debug_wb_rf_wnum
);
    timeunit 1ns;
    timeprecision 100ps;

    int violations = 0;

    // fetch port stays quiet in the first cycle out of reset
    assert property (@(posedge clk) $rose(rst_n) |-> !inst_re)
        else begin
            $error("inst_re high in the first cycle after reset");
            violations++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) inst_addr[1:0] == 2'b00)
        else begin
            $error("inst_addr not word aligned");
            violations++;
        end

    // all four byte enables mirror one write-back enable
    assert property (@(posedge clk) disable iff (!rst_n)
                     debug_wb_rf_we == 4'b0000 || debug_wb_rf_we == 4'b1111)
        else begin
            $error("debug_wb_rf_we bits differ");
            violations++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
                     debug_wb_rf_we[0] |-> debug_wb_rf_wnum != 5'd0)
        else begin
            $error("write-back to r0 reported");
            violations++;
        end

endmodule

`default_nettype wire

/* tests/core_tb.sv */
`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    localparam word_t reset_pc       = 32'h1c00_0000;
    localparam int    prog_len       = 200;
    localparam int    timeout_cycles = 4 * prog_len + 50;

    typedef enum int {
        k_add, k_sub, k_and, k_or, k_xor, k_slt,
        k_addi, k_ori, k_lui, k_cnt_lo, k_cnt_hi, k_bad
    } kind_t;

    logic        clk;
    logic        rst_n;
    word_t       inst_rdata;
    logic        inst_hit;
    logic        inst_re;
    word_t       inst_addr;
    word_t       debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    reg_addr_t   debug_wb_rf_wnum;
    word_t       debug_wb_rf_wdata;

    logic [31:0] lcg_state = 32'd83;
    kind_t       prog_kind [prog_len];
    reg_addr_t   prog_rd [prog_len];
    reg_addr_t   prog_rj [prog_len];
    reg_addr_t   prog_rk [prog_len];
    logic [19:0] prog_imm [prog_len];
    word_t       prog_mem [prog_len];
    word_t       model_regs [32];
    int          error_count = 0;
    int          writes_expected = 0;
    int          writes_seen = 0;
    int          cycle_count = 0;

    core #(
        .reset_pc (reset_pc)
    ) core_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_rdata        (inst_rdata),
        .inst_hit          (inst_hit),
        .inst_re           (inst_re),
        .inst_addr         (inst_addr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    bind core core_asserts core_asserts_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .inst_re          (inst_re),
        .inst_addr        (inst_addr),
        .debug_wb_rf_we   (debug_wb_rf_we),
        .debug_wb_rf_wnum (debug_wb_rf_wnum)
    );

    // ***********************************************************
    // random program and reference model
    // ***********************************************************

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:16]) % n;
    endfunction

    // LoongArch encodings of the generated subset
    function automatic word_t encode_inst(kind_t k, reg_addr_t rd, reg_addr_t rj,
                                          reg_addr_t rk, logic [19:0] imm);
        word_t r3;
        word_t i12;
        r3  = {17'd0, rk, rj, rd};
        i12 = {10'd0, imm[11:0], rj, rd};
        case (k)
            k_add:    return 32'h0010_0000 | r3;
            k_sub:    return 32'h0011_0000 | r3;
            k_slt:    return 32'h0012_0000 | r3;
            k_and:    return 32'h0014_8000 | r3;
            k_or:     return 32'h0015_0000 | r3;
            k_xor:    return 32'h0015_8000 | r3;
            k_addi:   return 32'h0280_0000 | i12;
            k_ori:    return 32'h0380_0000 | i12;
            k_lui:    return 32'h1400_0000 | {7'd0, imm, rd};
            k_cnt_lo: return 32'h0000_6000 | {27'd0, rd};
            k_cnt_hi: return 32'h0000_6400 | {27'd0, rd};
            default:  return {8'hff, imm, 4'h0};
        endcase
    endfunction

    function automatic word_t ref_result(kind_t k, word_t a, word_t b, logic [19:0] imm);
        word_t sx;
        word_t zx;
        sx = {{20{imm[11]}}, imm[11:0]};
        zx = {20'd0, imm[11:0]};
        case (k)
            k_add:   return a + b;
            k_sub:   return a - b;
            k_and:   return a & b;
            k_or:    return a | b;
            k_xor:   return a ^ b;
            k_slt:   return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            k_addi:  return a + sx;
            k_ori:   return a | zx;
            k_lui:   return {imm, 12'd0};
            // upper timer half stays zero over a short run
            default: return '0;
        endcase
    endfunction

    function automatic logic writes_reg(int i);
        return prog_kind[i] != k_bad && prog_rd[i] != 5'd0;
    endfunction

    function automatic word_t fetch_word(word_t addr);
        word_t off;
        off = (addr - reset_pc) >> 2;
        if (addr >= reset_pc && off < prog_len) begin
            return prog_mem[off];
        end
        return '0;
    endfunction

    task automatic build_program();
        logic [31:0] r;
        for (int i = 0; i < prog_len; i++) begin
            r = lcg_next();
            prog_imm[i] = r[31:12];
            if (i < 7) begin
                // r1..r7 get defined values first
                prog_kind[i] = k_addi;
                prog_rd[i]   = reg_addr_t'(i + 1);
                prog_rj[i]   = '0;
                prog_rk[i]   = '0;
            end else begin
                prog_kind[i] = kind_t'(rand_below(12));
                prog_rd[i]   = reg_addr_t'(rand_below(8));
                prog_rj[i]   = reg_addr_t'(rand_below(8));
                prog_rk[i]   = reg_addr_t'(rand_below(8));
            end
            if (prog_kind[i] == k_cnt_lo || prog_kind[i] == k_cnt_hi) begin
                prog_rj[i] = '0;
            end
            prog_mem[i] = encode_inst(prog_kind[i], prog_rd[i], prog_rj[i], prog_rk[i],
                                      prog_imm[i]);
            if (writes_reg(i)) begin
                writes_expected++;
            end
        end
    endtask

    // ***********************************************************
    // checks and end of run
    // ***********************************************************

    task automatic end_run();
        if (error_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "run stopped at first error");
        end
    endtask

    task automatic check_word(string what, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s expected %h, got %h", $time, what, expected, actual);
            error_count++;
            end_run();
        end
    endtask

    task automatic check_reg(reg_addr_t expected, reg_addr_t actual);
        if (actual !== expected) begin
            $display("Fail at %0d ns: destination expected r%0d, got r%0d",
                     $time, expected, actual);
            error_count++;
            end_run();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : stimulus
        rst_n = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        build_program();
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        wait (writes_seen == writes_expected);
        // a few idle cycles catch stray commits
        repeat (10) @(negedge clk);
        end_run();
    end

    // instruction memory, answers one cycle after each request
    initial begin : inst_memory
        logic  req_re;
        word_t req_addr;
        inst_rdata = '0;
        inst_hit   = 1'b0;
        forever begin
            @(negedge clk);
            req_re   = inst_re;
            req_addr = inst_addr;
            @(posedge clk);
            #2;
            inst_rdata = (req_re === 1'b1) ? fetch_word(req_addr) : '0;
            // about one miss in four
            inst_hit   = (req_re === 1'b1) && (rand_below(4) != 0);
        end
    end

    initial begin : watchdog
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= timeout_cycles) begin
                $display("Timeout after %0d cycles with commits missing, %0d of %0d seen",
                         cycle_count, writes_seen, writes_expected);
                error_count++;
                end_run();
            end
        end
    end

    initial begin : compare
        int    idx;
        int    cycle_no;
        int    last_cnt_cycle;
        word_t last_cnt_val;
        logic  have_cnt;
        word_t expected;
        idx            = 0;
        cycle_no       = 0;
        last_cnt_cycle = 0;
        last_cnt_val   = '0;
        have_cnt       = 1'b0;
        forever begin
            @(negedge clk);
            cycle_no++;
            if (core_inst.core_asserts_inst.violations != 0) begin
                $display("A bound assertion on the core ports failed at %0d ns", $time);
                error_count++;
                end_run();
            end
            if (rst_n === 1'b1 && debug_wb_rf_we !== 4'b0000) begin
                while (idx < prog_len && !writes_reg(idx)) begin
                    idx++;
                end
                if (idx >= prog_len) begin
                    $display("Unexpected commit at pc %h after the last writing instruction",
                             debug_wb_pc);
                    error_count++;
                    end_run();
                end
                check_word("commit pc", reset_pc + word_t'(4 * idx), debug_wb_pc);
                check_reg(prog_rd[idx], debug_wb_rf_wnum);
                if (prog_kind[idx] == k_cnt_lo) begin
                    // timer and commits both advance once per cycle
                    if (have_cnt) begin
                        expected = last_cnt_val + word_t'(cycle_no - last_cnt_cycle);
                        check_word("counter delta", expected, debug_wb_rf_wdata);
                    end
                    have_cnt       = 1'b1;
                    last_cnt_val   = debug_wb_rf_wdata;
                    last_cnt_cycle = cycle_no;
                end else begin
                    expected = ref_result(prog_kind[idx], model_regs[prog_rj[idx]],
                                          model_regs[prog_rk[idx]], prog_imm[idx]);
                    check_word($sformatf("data at pc %h", debug_wb_pc), expected,
                               debug_wb_rf_wdata);
                end
                model_regs[prog_rd[idx]] = debug_wb_rf_wdata;
                idx++;
                writes_seen++;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu (
    input  core_pkg::alu_op_t op,
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    output core_pkg::word_t   y
);
    import core_pkg::*;

    always_comb begin
        case (op)
            op_add: begin
                y = a + b;
            end
            op_sub: begin
                y = a - b;
            end
            op_and: begin
                y = a & b;
            end
            op_or: begin
                y = a | b;
            end
            op_xor: begin
                y = a ^ b;
            end
            op_slt: begin
                y = {31'd0, $signed(a) < $signed(b)};
            end
            // immediate already shifted by the decoder
            op_lui: begin
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/core.sv */
`default_nettype none

module core #(
    parameter core_pkg::word_t reset_pc = core_pkg::default_reset_pc
) (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::word_t     inst_rdata,
    input  logic                inst_hit,
    output logic                inst_re,
    output core_pkg::word_t     inst_addr,
    output core_pkg::word_t     debug_wb_pc,
    output logic [3:0]          debug_wb_rf_we,
    output core_pkg::reg_addr_t debug_wb_rf_wnum,
    output core_pkg::word_t     debug_wb_rf_wdata
);
    import core_pkg::*;

    fetch_t   fetch;
    decoded_t dec;
    word_t    rj_data;
    word_t    rk_data;
    word_t    timer_half;
    logic     timer_sel_hi;
    wb_t      wb;

    fetch_ctrl #(
        .reset_pc (reset_pc)
    ) u_fetch_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_rdata (inst_rdata),
        .inst_hit   (inst_hit),
        .inst_re    (inst_re),
        .inst_addr  (inst_addr),
        .fetch      (fetch)
    );

    decoder u_decoder (
        .fetch (fetch),
        .dec   (dec)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rj_addr (dec.rj),
        .rk_addr (dec.rk),
        .wb      (wb),
        .rj_data (rj_data),
        .rk_data (rk_data)
    );

    exec_stage u_exec_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec          (dec),
        .rj_data      (rj_data),
        .rk_data      (rk_data),
        .timer_half   (timer_half),
        .timer_sel_hi (timer_sel_hi),
        .wb           (wb)
    );

    stable_timer u_stable_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .sel_hi (timer_sel_hi),
        .half   (timer_half)
    );

    // debug trace from the write-back record
    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_we    = {4{wb.valid && wb.we}};
    assign debug_wb_rf_wnum  = wb.rd;
    assign debug_wb_rf_wdata = wb.data;

endmodule

`default_nettype wire

/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    // ***********************************************************
    // basic widths
    // ***********************************************************

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;

    localparam word_t default_reset_pc = 32'h1c00_0000;

    // internal operation codes
    localparam alu_op_t op_add    = 4'd0;
    localparam alu_op_t op_sub    = 4'd1;
    localparam alu_op_t op_and    = 4'd2;
    localparam alu_op_t op_or     = 4'd3;
    localparam alu_op_t op_xor    = 4'd4;
    localparam alu_op_t op_slt    = 4'd5;
    localparam alu_op_t op_lui    = 4'd6;
    localparam alu_op_t op_cnt_lo = 4'd7;
    localparam alu_op_t op_cnt_hi = 4'd8;
    // bubble, also used for anything not decoded
    localparam alu_op_t op_nop    = 4'd15;

    // ***********************************************************
    // records passed between stages
    // ***********************************************************

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } fetch_t;

    typedef struct packed {
        word_t     pc;
        alu_op_t   op;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        word_t     imm;
        logic      use_imm;
        logic      we;
    } decoded_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

/* verilog/decoder.sv */
`default_nettype none

module decoder (
    input  core_pkg::fetch_t   fetch,
    output core_pkg::decoded_t dec
);
    import core_pkg::*;

    word_t   inst;
    alu_op_t op;
    logic    known;
    logic    use_imm;
    word_t   imm;

    assign inst = fetch.inst;

    // ***********************************************************
    // opcode match
    // ***********************************************************

    always_comb begin
        op      = op_nop;
        known   = 1'b1;
        use_imm = 1'b0;
        imm     = '0;
        if (inst[31:15] == 17'h00020) begin
            op = op_add;
        end else if (inst[31:15] == 17'h00022) begin
            op = op_sub;
        end else if (inst[31:15] == 17'h00024) begin
            op = op_slt;
        end else if (inst[31:15] == 17'h00029) begin
            op = op_and;
        end else if (inst[31:15] == 17'h0002a) begin
            op = op_or;
        end else if (inst[31:15] == 17'h0002b) begin
            op = op_xor;
        end else if (inst[31:22] == 10'h00a) begin
            // addi.w, si12
            op      = op_add;
            use_imm = 1'b1;
            imm     = {{20{inst[21]}}, inst[21:10]};
        end else if (inst[31:22] == 10'h00e) begin
            // ori, ui12
            op      = op_or;
            use_imm = 1'b1;
            imm     = {20'd0, inst[21:10]};
        end else if (inst[31:25] == 7'h0a) begin
            // lu12i.w
            op      = op_lui;
            use_imm = 1'b1;
            imm     = {inst[24:5], 12'd0};
        end else if (inst[31:10] == 22'h000018 && inst[9:5] == 5'd0) begin
            op = op_cnt_lo;
        end else if (inst[31:10] == 22'h000019 && inst[9:5] == 5'd0) begin
            op = op_cnt_hi;
        end else begin
            known = 1'b0;
        end
    end

    // ***********************************************************
    // decoded record
    // ***********************************************************

    always_comb begin
        dec.pc      = fetch.pc;
        dec.op      = fetch.valid ? op : op_nop;
        dec.rd      = inst[4:0];
        dec.rj      = inst[9:5];
        dec.rk      = inst[14:10];
        dec.imm     = imm;
        dec.use_imm = use_imm;
        // r0 writes still flow down, just without a write
        dec.we      = fetch.valid && known && (inst[4:0] != 5'd0);
    end

endmodule

`default_nettype wire

/* verilog/exec_stage.sv */
`default_nettype none

module exec_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::decoded_t dec,
    input  core_pkg::word_t    rj_data,
    input  core_pkg::word_t    rk_data,
    input  core_pkg::word_t    timer_half,
    output logic               timer_sel_hi,
    output core_pkg::wb_t      wb
);
    import core_pkg::*;

    decoded_t ex_dec;
    word_t    ex_rj;
    word_t    ex_rk;
    logic     ex_valid;
    logic     ex_fwd_ok;
    logic     wb_fwd_ok;
    word_t    fwd_rj;
    word_t    fwd_rk;
    word_t    alu_b;
    word_t    alu_y;
    word_t    ex_result;
    logic     is_cnt;

    // ***********************************************************
    // operand forwarding into the decode/execute register
    // ***********************************************************

    assign ex_fwd_ok = ex_valid && ex_dec.we;
    assign wb_fwd_ok = wb.valid && wb.we;

    // newest producer wins
    assign fwd_rj = (ex_fwd_ok && ex_dec.rd == dec.rj) ? ex_result :
                    (wb_fwd_ok && wb.rd == dec.rj)     ? wb.data   : rj_data;
    assign fwd_rk = (ex_fwd_ok && ex_dec.rd == dec.rk) ? ex_result :
                    (wb_fwd_ok && wb.rd == dec.rk)     ? wb.data   : rk_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_dec.op <= op_nop;
            ex_dec.we <= 1'b0;
        end else begin
            ex_dec <= dec;
        end
    end

    always_ff @(posedge clk) begin
        ex_rj <= fwd_rj;
        ex_rk <= fwd_rk;
    end

    // ***********************************************************
    // execute
    // ***********************************************************

    assign ex_valid     = (ex_dec.op != op_nop);
    assign alu_b        = ex_dec.use_imm ? ex_dec.imm : ex_rk;
    assign is_cnt       = (ex_dec.op == op_cnt_lo) || (ex_dec.op == op_cnt_hi);
    assign timer_sel_hi = (ex_dec.op == op_cnt_hi);

    alu u_alu (
        .op (ex_dec.op),
        .a  (ex_rj),
        .b  (alu_b),
        .y  (alu_y)
    );

    // counter reads take the timer half seen this cycle
    assign ex_result = is_cnt ? timer_half : alu_y;

    // execute/write-back register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
            wb.we    <= 1'b0;
        end else begin
            wb.valid <= ex_valid;
            wb.we    <= ex_dec.we;
            wb.pc    <= ex_dec.pc;
            wb.rd    <= ex_dec.rd;
            wb.data  <= ex_result;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_ctrl.sv */
`default_nettype none

module fetch_ctrl #(
    parameter core_pkg::word_t reset_pc = core_pkg::default_reset_pc
) (
    input  logic             clk,
    input  logic             rst_n,
    input  core_pkg::word_t  inst_rdata,
    input  logic             inst_hit,
    output logic             inst_re,
    output core_pkg::word_t  inst_addr,
    output core_pkg::fetch_t fetch
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_replay
    } fetch_state_t;

    fetch_state_t state;
    word_t        next_pc;
    word_t        resp_pc;
    logic         resp_pend;
    logic         resp_miss;

    // response of last cycle's request came back without hit
    assign resp_miss = resp_pend && !inst_hit;

    // ***********************************************************
    // fetch FSM
    // ***********************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            inst_re   <= 1'b0;
            resp_pend <= 1'b0;
        end else begin
            resp_pend <= inst_re;
            case (state)
                st_idle: begin
                    state   <= st_run;
                    inst_re <= 1'b1;
                end
                st_run: begin
                    if (resp_miss) begin
                        state <= st_replay;
                    end
                end
                // the A+4 response is dropped here, resume streaming
                st_replay: begin
                    state <= st_run;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // address path, two requests in flight
    always_ff @(posedge clk) begin
        resp_pc <= inst_addr;
        if (!rst_n) begin
            inst_addr <= reset_pc;
            next_pc   <= reset_pc;
        end else if (state == st_run && resp_miss) begin
            inst_addr <= resp_pc;
            next_pc   <= resp_pc + 32'd4;
        end else begin
            inst_addr <= next_pc;
            next_pc   <= next_pc + 32'd4;
        end
    end

    assign fetch = '{
        valid: (state == st_run) && resp_pend && inst_hit,
        pc:    resp_pc,
        inst:  inst_rdata
    };

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::reg_addr_t rj_addr,
    input  core_pkg::reg_addr_t rk_addr,
    input  core_pkg::wb_t       wb,
    output core_pkg::word_t     rj_data,
    output core_pkg::word_t     rk_data
);
    import core_pkg::*;

    // r0 has no storage
    word_t regs [1:31];
    logic  wr_req;

    assign wr_req = wb.valid && wb.we;

    always_ff @(posedge clk) begin
        if (rst_n && wr_req && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-through for a same-cycle write
    always_comb begin
        if (rj_addr == 5'd0) begin
            rj_data = '0;
        end else if (wr_req && wb.rd == rj_addr) begin
            rj_data = wb.data;
        end else begin
            rj_data = regs[rj_addr];
        end
    end

    always_comb begin
        if (rk_addr == 5'd0) begin
            rk_data = '0;
        end else if (wr_req && wb.rd == rk_addr) begin
            rk_data = wb.data;
        end else begin
            rk_data = regs[rk_addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/stable_timer.sv */
`default_nettype none

module stable_timer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            sel_hi,
    output core_pkg::word_t half
);

    logic [63:0] count;

    // free running, zero in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count + 64'd1;
        end
    end

    assign half = sel_hi ? count[63:32] : count[31:0];

endmodule

`default_nettype wire
